//--- hdl/bram_fifo_pkg.sv
// ==========================================================
// shared widths, width-mode encoding, register map and AXI
// response codes for the block RAM / FIFO.
// ==========================================================
package bram_fifo_pkg;

	// storage row and port data word.
	localparam int WORD_BITS = 18;
	typedef logic [WORD_BITS-1:0] word_t;

	// port width select. unlisted codes disable the port.
	typedef enum logic [2:0] {
		MODE_OFF = 3'b000,
		MODE_1   = 3'b001,
		MODE_2   = 3'b010,
		MODE_4   = 3'b100,
		MODE_9   = 3'b101,
		MODE_18  = 3'b110
	} width_mode_t;

	// thresholds and occupancy.
	typedef logic [10:0] thresh_t;

	// ==========================================================
	// AXI4-Lite configuration bus
	// ==========================================================
	typedef logic [31:0] axi_data_t;
	typedef logic [3:0]  axi_addr_t;

	localparam axi_addr_t REG_CTRL   = 4'h0;
	localparam axi_addr_t REG_THRESH = 4'h4;
	localparam axi_addr_t REG_STATUS = 4'h8;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- hdl/bram_cfg_if.sv
// ==========================================================
// configuration and status between register block and core.
// ==========================================================
`timescale 1ns/1ps

interface bram_cfg_if;
	import bram_fifo_pkg::*;

	width_mode_t wmode;
	width_mode_t rmode;
	logic        fifo_mode;
	logic        flush;
	thresh_t     upaf;
	thresh_t     upae;
	logic        empty;
	logic        almost_empty;
	logic        full;
	logic        almost_full;
	logic        overrun;
	logic        underrun;

	modport regs (
		output wmode, rmode, fifo_mode, flush, upaf, upae,
		input  empty, almost_empty, full, almost_full, overrun, underrun
	);

	modport core (
		input  wmode, rmode, fifo_mode, flush, upaf, upae,
		output empty, almost_empty, full, almost_full, overrun, underrun
	);

endinterface

//--- hdl/sram_dp.sv
// ==========================================================
// one write port, one registered read port, bit write mask.
// ==========================================================
`timescale 1ns/1ps

module sram_dp #(
	parameter int ROW_BITS = 10
) (
	input  logic                 CLK_A,
	input  logic                 wen,
	input  logic [ROW_BITS-1:0]  waddr,
	input  bram_fifo_pkg::word_t wdata,
	input  bram_fifo_pkg::word_t wmask,
	input  logic                 ren,
	input  logic [ROW_BITS-1:0]  raddr,
	output bram_fifo_pkg::word_t rdata
);
	import bram_fifo_pkg::*;

	localparam int ROWS = 1 << ROW_BITS;

	word_t mem [ROWS];

	// a set mask bit protects the stored bit.
	always_ff @(posedge CLK_A) begin
		if (wen) begin
			for (int i = 0; i < WORD_BITS; i++) begin
				if (!wmask[i]) begin
					mem[waddr][i] <= wdata[i];
				end
			end
		end
	end

	// read returns the old row on a same-cycle write.
	always_ff @(posedge CLK_A) begin
		if (ren) begin
			rdata <= mem[raddr];
		end
	end

endmodule

//--- hdl/fifo_ctl.sv
// ==========================================================
// synchronous FIFO pointers, occupancy count and flags.
// ==========================================================
`timescale 1ns/1ps

module fifo_ctl #(
	parameter int ROW_BITS = 10
) (
	input  logic                CLK_A,
	input  logic                arst_n,
	bram_cfg_if.core            cfg,
	input  logic                push,
	input  logic                pop,
	output logic [ROW_BITS-1:0] waddr,
	output logic [ROW_BITS-1:0] raddr
);
	import bram_fifo_pkg::*;

	localparam thresh_t DEPTH = thresh_t'(1 << ROW_BITS);

	thresh_t count;
	logic    push_ok;
	logic    pop_ok;
	logic    overrun_q;
	logic    underrun_q;

	// a push while full and a pop while empty are dropped.
	assign push_ok = push & ~cfg.full;
	assign pop_ok  = pop & ~cfg.empty;

	always_ff @(posedge CLK_A or negedge arst_n) begin
		if (!arst_n) begin
			waddr      <= '0;
			raddr      <= '0;
			count      <= '0;
			overrun_q  <= 1'b0;
			underrun_q <= 1'b0;
		end else if (cfg.flush) begin
			waddr      <= '0;
			raddr      <= '0;
			count      <= '0;
			overrun_q  <= 1'b0;
			underrun_q <= 1'b0;
		end else begin
			if (push_ok) begin
				waddr <= waddr + 1'b1;
			end
			if (pop_ok) begin
				raddr <= raddr + 1'b1;
			end
			if (push_ok && !pop_ok) begin
				count <= count + 1'b1;
			end else if (pop_ok && !push_ok) begin
				count <= count - 1'b1;
			end
			if (push && cfg.full) begin
				overrun_q <= 1'b1;
			end
			if (pop && cfg.empty) begin
				underrun_q <= 1'b1;
			end
		end
	end

	// ==========================================================
	// flags, decoded from the registered count
	// ==========================================================
	assign cfg.empty        = (count == '0);
	assign cfg.full         = (count == DEPTH);
	// count >= depth - upaf, kept free of underflow.
	assign cfg.almost_full  = ({1'b0, count} + {1'b0, cfg.upaf}) >= {1'b0, DEPTH};
	assign cfg.almost_empty = (count <= cfg.upae);
	assign cfg.overrun      = overrun_q;
	assign cfg.underrun     = underrun_q;

	assert property (@(posedge CLK_A) disable iff (!arst_n) count <= DEPTH);

endmodule

//--- hdl/lane_align.sv
// ==========================================================
// write lane replication and masking, read lane extraction,
// and FIFO/RAM address selection around the FIFO controller.
// ==========================================================
`timescale 1ns/1ps

module lane_align #(
	parameter int ROW_BITS = 10
) (
	input  logic                  CLK_A,
	input  logic                  arst_n,
	bram_cfg_if.core              cfg,
	input  logic                  wen_a,
	input  logic [ROW_BITS+3:0]   addr_a,
	input  bram_fifo_pkg::word_t  wdata_a,
	input  logic [1:0]            be_a,
	input  logic                  ren_b,
	input  logic [ROW_BITS+3:0]   addr_b,
	input  bram_fifo_pkg::word_t  ram_rdata,
	output logic                  ram_wen,
	output logic [ROW_BITS-1:0]   ram_waddr_row,
	output bram_fifo_pkg::word_t  ram_wdata,
	output bram_fifo_pkg::word_t  ram_wmask,
	output logic                  ram_ren,
	output logic [ROW_BITS-1:0]   ram_raddr_row,
	output bram_fifo_pkg::word_t  rdata_b
);
	import bram_fifo_pkg::*;

	logic                push;
	logic                pop;
	logic [ROW_BITS-1:0] fifo_waddr;
	logic [ROW_BITS-1:0] fifo_raddr;
	logic [3:0]          wsub;
	logic [3:0]          rd_sub;
	logic                rd_fifo;

	assign push = cfg.fifo_mode & wen_a;
	assign pop  = cfg.fifo_mode & ren_b;
	assign wsub = addr_a[3:0];

	// FIFO mode: pointers address whole rows, flags gate the strobes.
	assign ram_wen       = cfg.fifo_mode ? (push & ~cfg.full) : wen_a;
	assign ram_ren       = cfg.fifo_mode ? (pop & ~cfg.empty) : ren_b;
	assign ram_waddr_row = cfg.fifo_mode ? fifo_waddr : addr_a[ROW_BITS+3:4];
	assign ram_raddr_row = cfg.fifo_mode ? fifo_raddr : addr_b[ROW_BITS+3:4];

	fifo_ctl #(
		.ROW_BITS(ROW_BITS)
	) i_fifo_ctl (
		.CLK_A (CLK_A),
		.arst_n(arst_n),
		.cfg   (cfg),
		.push  (push),
		.pop   (pop),
		.waddr (fifo_waddr),
		.raddr (fifo_raddr)
	);

	// mask bit 1 keeps the stored bit.
	always_comb begin
		ram_wdata = wdata_a;
		ram_wmask = '1;
		if (cfg.fifo_mode) begin
			ram_wmask = '0;
		end else begin
			case (cfg.wmode)
				MODE_18: begin
					{ram_wmask[17], ram_wmask[15:8]} = {9{~be_a[1]}};
					{ram_wmask[16], ram_wmask[7:0]}  = {9{~be_a[0]}};
				end
				MODE_9: begin
					ram_wdata = {{2{wdata_a[8]}}, {2{wdata_a[7:0]}}};
					{ram_wmask[17], ram_wmask[15:8]} = {9{~wsub[3]}};
					{ram_wmask[16], ram_wmask[7:0]}  = {9{wsub[3]}};
				end
				MODE_4: begin
					ram_wdata = {2'b00, {4{wdata_a[3:0]}}};
					ram_wmask[{wsub[3:2], 2'b00} +: 4] = 4'h0;
				end
				MODE_2: begin
					ram_wdata = {2'b00, {8{wdata_a[1:0]}}};
					ram_wmask[{wsub[3:1], 1'b0} +: 2] = 2'b00;
				end
				MODE_1: begin
					ram_wdata = {2'b00, {16{wdata_a[0]}}};
					ram_wmask[wsub] = 1'b0;
				end
				default: ram_wmask = '1;
			endcase
		end
	end

	// lane select follows the registered read data.
	always_ff @(posedge CLK_A or negedge arst_n) begin
		if (!arst_n) begin
			rd_sub  <= '0;
			rd_fifo <= 1'b0;
		end else if (ram_ren) begin
			rd_sub  <= addr_b[3:0];
			rd_fifo <= cfg.fifo_mode;
		end
	end

	always_comb begin
		rdata_b = '0;
		if (rd_fifo) begin
			rdata_b = ram_rdata;
		end else begin
			case (cfg.rmode)
				MODE_18: rdata_b = ram_rdata;
				MODE_9:  rdata_b[8:0] = rd_sub[3] ? {ram_rdata[17], ram_rdata[15:8]}
					: {ram_rdata[16], ram_rdata[7:0]};
				MODE_4:  rdata_b[3:0] = ram_rdata[{rd_sub[3:2], 2'b00} +: 4];
				MODE_2:  rdata_b[1:0] = ram_rdata[{rd_sub[3:1], 1'b0} +: 2];
				MODE_1:  rdata_b[0] = ram_rdata[rd_sub];
				default: rdata_b = '0;
			endcase
		end
	end

endmodule

//--- hdl/bram_regs.sv
// ==========================================================
// AXI4-Lite slave with CTRL, THRESH and STATUS registers.
// ==========================================================
`timescale 1ns/1ps

module bram_regs (
	input  logic                     CLK_A,
	input  logic                     arst_n,
	input  bram_fifo_pkg::axi_addr_t awaddr,
	input  logic                     awvalid,
	output logic                     awready,
	input  bram_fifo_pkg::axi_data_t wdata,
	input  logic [3:0]               wstrb,
	input  logic                     wvalid,
	output logic                     wready,
	output logic [1:0]               bresp,
	output logic                     bvalid,
	input  logic                     bready,
	input  bram_fifo_pkg::axi_addr_t araddr,
	input  logic                     arvalid,
	output logic                     arready,
	output bram_fifo_pkg::axi_data_t rdata,
	output logic [1:0]               rresp,
	output logic                     rvalid,
	input  logic                     rready,
	bram_cfg_if.regs                 cfg
);
	import bram_fifo_pkg::*;

	typedef enum logic {W_IDLE, W_RESP} wstate_t;
	typedef enum logic {R_IDLE, R_RESP} rstate_t;

	wstate_t   w_state;
	rstate_t   r_state;
	axi_data_t strb_mask;
	axi_data_t ctrl_word;
	axi_data_t thresh_word;
	axi_data_t status_word;
	axi_data_t ctrl_new;
	axi_data_t thresh_new;
	axi_data_t rd_word;
	logic      rd_ok;
	logic      wr_ok;

	// register images as seen on the bus. flush always reads 0.
	assign ctrl_word   = {22'd0, 1'b0, cfg.fifo_mode, 2'b00, cfg.rmode, cfg.wmode};
	assign thresh_word = {5'd0, cfg.upae, 5'd0, cfg.upaf};
	assign status_word = {26'd0, cfg.underrun, cfg.overrun, cfg.almost_full,
		cfg.full, cfg.almost_empty, cfg.empty};

	assign strb_mask  = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
	assign ctrl_new   = (ctrl_word & ~strb_mask) | (wdata & strb_mask);
	assign thresh_new = (thresh_word & ~strb_mask) | (wdata & strb_mask);
	assign wr_ok      = (awaddr == REG_CTRL) || (awaddr == REG_THRESH);

	assign bvalid = (w_state == W_RESP);
	assign rvalid = (r_state == R_RESP);

	// ==========================================================
	// write channel
	// ==========================================================
	always_ff @(posedge CLK_A or negedge arst_n) begin
		if (!arst_n) begin
			w_state       <= W_IDLE;
			awready       <= 1'b0;
			wready        <= 1'b0;
			bresp         <= RESP_OKAY;
			cfg.wmode     <= MODE_OFF;
			cfg.rmode     <= MODE_OFF;
			cfg.fifo_mode <= 1'b0;
			cfg.flush     <= 1'b0;
			cfg.upaf      <= '0;
			cfg.upae      <= '0;
		end else begin
			cfg.flush <= 1'b0;
			case (w_state)
				W_IDLE: begin
					if (awready) begin
						// address and data handshake completes this cycle.
						awready <= 1'b0;
						wready  <= 1'b0;
						w_state <= W_RESP;
						bresp   <= wr_ok ? RESP_OKAY : RESP_SLVERR;
						if (awaddr == REG_CTRL) begin
							cfg.wmode     <= width_mode_t'(ctrl_new[2:0]);
							cfg.rmode     <= width_mode_t'(ctrl_new[5:3]);
							cfg.fifo_mode <= ctrl_new[8];
							cfg.flush     <= wdata[9] & wstrb[1];
						end
						if (awaddr == REG_THRESH) begin
							cfg.upaf <= thresh_new[10:0];
							cfg.upae <= thresh_new[26:16];
						end
					end else if (awvalid && wvalid) begin
						awready <= 1'b1;
						wready  <= 1'b1;
					end
				end
				W_RESP: begin
					if (bready) begin
						w_state <= W_IDLE;
					end
				end
			endcase
		end
	end

	// ==========================================================
	// read channel
	// ==========================================================
	always_comb begin
		rd_ok = 1'b1;
		case (araddr)
			REG_CTRL:   rd_word = ctrl_word;
			REG_THRESH: rd_word = thresh_word;
			REG_STATUS: rd_word = status_word;
			default: begin
				rd_word = '0;
				rd_ok   = 1'b0;
			end
		endcase
	end

	always_ff @(posedge CLK_A or negedge arst_n) begin
		if (!arst_n) begin
			r_state <= R_IDLE;
			arready <= 1'b0;
			rdata   <= '0;
			rresp   <= RESP_OKAY;
		end else begin
			case (r_state)
				R_IDLE: begin
					if (arready) begin
						arready <= 1'b0;
						r_state <= R_RESP;
						rdata   <= rd_word;
						rresp   <= rd_ok ? RESP_OKAY : RESP_SLVERR;
					end else if (arvalid) begin
						arready <= 1'b1;
					end
				end
				R_RESP: begin
					if (rready) begin
						r_state <= R_IDLE;
					end
				end
			endcase
		end
	end

	// responses hold, unchanged, until the master takes them.
	assert property (@(posedge CLK_A) disable iff (!arst_n)
		bvalid && !bready |=> bvalid && $stable(bresp));
	assert property (@(posedge CLK_A) disable iff (!arst_n)
		rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

//--- hdl/bram_fifo.sv
// ==========================================================
// top level: register block, lane logic and memory core.
// ==========================================================
`timescale 1ns/1ps

module bram_fifo #(
	parameter int ROW_BITS = 10
) (
	input  logic                     CLK_A,
	input  logic                     arst_n,
	input  bram_fifo_pkg::axi_addr_t awaddr,
	input  logic                     awvalid,
	output logic                     awready,
	input  bram_fifo_pkg::axi_data_t wdata,
	input  logic [3:0]               wstrb,
	input  logic                     wvalid,
	output logic                     wready,
	output logic [1:0]               bresp,
	output logic                     bvalid,
	input  logic                     bready,
	input  bram_fifo_pkg::axi_addr_t araddr,
	input  logic                     arvalid,
	output logic                     arready,
	output bram_fifo_pkg::axi_data_t rdata,
	output logic [1:0]               rresp,
	output logic                     rvalid,
	input  logic                     rready,
	input  logic                     wen_a,
	input  logic [ROW_BITS+3:0]      addr_a,
	input  bram_fifo_pkg::word_t     wdata_a,
	input  logic [1:0]               be_a,
	input  logic                     ren_b,
	input  logic [ROW_BITS+3:0]      addr_b,
	output bram_fifo_pkg::word_t     rdata_b,
	output logic                     empty,
	output logic                     almost_empty,
	output logic                     full,
	output logic                     almost_full,
	output logic                     overrun,
	output logic                     underrun
);
	import bram_fifo_pkg::*;

	logic                ram_wen;
	logic                ram_ren;
	logic [ROW_BITS-1:0] ram_waddr_row;
	logic [ROW_BITS-1:0] ram_raddr_row;
	word_t               ram_wdata;
	word_t               ram_wmask;
	word_t               ram_rdata;

	bram_cfg_if cfg ();

	assign empty        = cfg.empty;
	assign almost_empty = cfg.almost_empty;
	assign full         = cfg.full;
	assign almost_full  = cfg.almost_full;
	assign overrun      = cfg.overrun;
	assign underrun     = cfg.underrun;

	bram_regs i_regs (
		.CLK_A  (CLK_A),
		.arst_n (arst_n),
		.awaddr (awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata  (wdata),
		.wstrb  (wstrb),
		.wvalid (wvalid),
		.wready (wready),
		.bresp  (bresp),
		.bvalid (bvalid),
		.bready (bready),
		.araddr (araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata  (rdata),
		.rresp  (rresp),
		.rvalid (rvalid),
		.rready (rready),
		.cfg    (cfg.regs)
	);

	lane_align #(
		.ROW_BITS(ROW_BITS)
	) i_lane (
		.CLK_A        (CLK_A),
		.arst_n       (arst_n),
		.cfg          (cfg.core),
		.wen_a        (wen_a),
		.addr_a       (addr_a),
		.wdata_a      (wdata_a),
		.be_a         (be_a),
		.ren_b        (ren_b),
		.addr_b       (addr_b),
		.ram_rdata    (ram_rdata),
		.ram_wen      (ram_wen),
		.ram_waddr_row(ram_waddr_row),
		.ram_wdata    (ram_wdata),
		.ram_wmask    (ram_wmask),
		.ram_ren      (ram_ren),
		.ram_raddr_row(ram_raddr_row),
		.rdata_b      (rdata_b)
	);

	sram_dp #(
		.ROW_BITS(ROW_BITS)
	) i_sram (
		.CLK_A(CLK_A),
		.wen  (ram_wen),
		.waddr(ram_waddr_row),
		.wdata(ram_wdata),
		.wmask(ram_wmask),
		.ren  (ram_ren),
		.raddr(ram_raddr_row),
		.rdata(ram_rdata)
	);

endmodule

//--- test/tb_clock.sv
// ==========================================================
// testbench clock and active-low reset.
// ==========================================================
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic CLK_A,
	output logic arst_n
);

	initial begin
		CLK_A = 1'b0;
		forever #(PERIOD_NS / 2) CLK_A = ~CLK_A;
	end

	// release on a falling edge, away from the sampling edge.
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK_A);
		@(negedge CLK_A);
		arst_n = 1'b1;
	end

endmodule

//--- test/bram_fifo_tb.sv
// ==========================================================
// testbench for the block RAM / FIFO with stimulus, reference
// model, comparison and reporting.
// ==========================================================
`timescale 1ns/1ps

module bram_fifo_tb;
	import bram_fifo_pkg::*;

	localparam int ROW_BITS  = 10;
	localparam int ADDR_BITS = ROW_BITS + 4;
	localparam int DEPTH     = 1 << ROW_BITS;
	// the tests need about 6000 cycles.
	localparam int MAX_CYCLES = 20000;
	localparam logic [31:0] RAND_SEED = 32'h9dfe_4012;

	logic                 CLK_A;
	logic                 arst_n;
	axi_addr_t            awaddr;
	logic                 awvalid;
	logic                 awready;
	axi_data_t            wdata;
	logic [3:0]           wstrb;
	logic                 wvalid;
	logic                 wready;
	logic [1:0]           bresp;
	logic                 bvalid;
	logic                 bready;
	axi_addr_t            araddr;
	logic                 arvalid;
	logic                 arready;
	axi_data_t            rdata;
	logic [1:0]           rresp;
	logic                 rvalid;
	logic                 rready;
	logic                 wen_a;
	logic [ADDR_BITS-1:0] addr_a;
	word_t                wdata_a;
	logic [1:0]           be_a;
	logic                 ren_b;
	logic [ADDR_BITS-1:0] addr_b;
	word_t                rdata_b;
	logic                 empty;
	logic                 almost_empty;
	logic                 full;
	logic                 almost_full;
	logic                 overrun;
	logic                 underrun;

	// reference model state.
	word_t       shadow [DEPTH];
	word_t       fifo_q [$];
	logic        m_ovr;
	logic        m_und;
	int          m_upaf;
	int          m_upae;
	width_mode_t cur_wmode;
	width_mode_t cur_rmode;

	// expected responses wait here until the cycle after the request.
	word_t      rd_exp_q [$];
	logic [5:0] fl_exp_q [$];
	logic       expect_rd;
	logic       expect_fl;
	logic       rd_due = 1'b0;
	logic       fl_due = 1'b0;

	string cur_test;
	int    err_count;
	int    errs_at_start;
	int    tests_run;
	int    tests_failed;

	tb_clock #(
		.PERIOD_NS   (20),
		.RESET_CYCLES(4)
	) i_clock (
		.CLK_A (CLK_A),
		.arst_n(arst_n)
	);

	bram_fifo #(
		.ROW_BITS(ROW_BITS)
	) i_dut (.*);

	// ==========================================================
	// reference functions
	// ==========================================================
	function automatic word_t ref_merge(word_t row, width_mode_t m, logic [3:0] sub,
		word_t d, logic [1:0] be);
		word_t r;
		int    base;
		int    i;
		r = row;
		case (m)
			MODE_18: begin
				if (be[0]) begin
					r[7:0] = d[7:0];
					r[16]  = d[16];
				end
				if (be[1]) begin
					r[15:8] = d[15:8];
					r[17]   = d[17];
				end
			end
			MODE_9: begin
				if (sub[3]) begin
					r[15:8] = d[7:0];
					r[17]   = d[8];
				end else begin
					r[7:0] = d[7:0];
					r[16]  = d[8];
				end
			end
			MODE_4: begin
				base = 4 * sub[3:2];
				for (i = 0; i < 4; i++) r[base+i] = d[i];
			end
			MODE_2: begin
				base = 2 * sub[3:1];
				for (i = 0; i < 2; i++) r[base+i] = d[i];
			end
			MODE_1: r[sub] = d[0];
			default: r = row;
		endcase
		return r;
	endfunction

	function automatic word_t ref_extract(word_t row, width_mode_t m, logic [3:0] sub);
		word_t r;
		int    base;
		int    i;
		r = '0;
		case (m)
			MODE_18: r = row;
			MODE_9:  r[8:0] = sub[3] ? {row[17], row[15:8]} : {row[16], row[7:0]};
			MODE_4: begin
				base = 4 * sub[3:2];
				for (i = 0; i < 4; i++) r[i] = row[base+i];
			end
			MODE_2: begin
				base = 2 * sub[3:1];
				for (i = 0; i < 2; i++) r[i] = row[base+i];
			end
			MODE_1:  r[0] = row[sub];
			default: r = '0;
		endcase
		return r;
	endfunction

	// bit order matches STATUS with empty in bit 0 and underrun in bit 5.
	function automatic logic [5:0] ref_flags(int cnt, int af, int ae, logic ovr, logic und);
		logic [5:0] f;
		f[0] = (cnt == 0);
		f[1] = (cnt <= ae);
		f[2] = (cnt == DEPTH);
		f[3] = (cnt >= DEPTH - af);
		f[4] = ovr;
		f[5] = und;
		return f;
	endfunction

	function automatic word_t fill_word(int row);
		return word_t'(row * 613) ^ 18'h2c9b3;
	endfunction

	// ==========================================================
	// reporting
	// ==========================================================
	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		err_count++;
		$display("FAILED %s: %s, expected %0h, actual %0h", cur_test, what, expected, actual);
	endtask

	task automatic begin_test(input string name);
		cur_test      = name;
		errs_at_start = err_count;
	endtask

	task automatic end_test();
		int errs;
		repeat (2) @(negedge CLK_A);
		errs = err_count - errs_at_start;
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("test %-12s %s, %0d errors", cur_test, (errs == 0) ? "ok" : "failed", errs);
	endtask

	// ==========================================================
	// AXI4-Lite master
	// ==========================================================
	task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
		output logic [1:0] resp);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		while (awready !== 1'b1) @(negedge CLK_A);
		if (wready !== 1'b1) report_mismatch("wready with awready", 1, wready);
		@(negedge CLK_A);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (bvalid !== 1'b1) @(negedge CLK_A);
		resp   = bresp;
		bready = 1'b1;
		@(negedge CLK_A);
		bready = 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t addr, output axi_data_t data,
		output logic [1:0] resp);
		araddr  = addr;
		arvalid = 1'b1;
		while (arready !== 1'b1) @(negedge CLK_A);
		@(negedge CLK_A);
		arvalid = 1'b0;
		while (rvalid !== 1'b1) @(negedge CLK_A);
		data   = rdata;
		resp   = rresp;
		rready = 1'b1;
		@(negedge CLK_A);
		rready = 1'b0;
	endtask

	task automatic set_ctrl(input width_mode_t wm, input width_mode_t rm, input logic fifo,
		input logic flush);
		logic [1:0] resp;
		axi_write(REG_CTRL, {22'd0, flush, fifo, 2'b00, rm, wm}, resp);
		if (resp !== RESP_OKAY) report_mismatch("CTRL write response", RESP_OKAY, resp);
		cur_wmode = wm;
		cur_rmode = rm;
		if (flush) begin
			fifo_q.delete();
			m_ovr = 1'b0;
			m_und = 1'b0;
		end
	endtask

	task automatic set_thresh(input thresh_t af, input thresh_t ae);
		logic [1:0] resp;
		axi_write(REG_THRESH, {5'd0, ae, 5'd0, af}, resp);
		if (resp !== RESP_OKAY) report_mismatch("THRESH write response", RESP_OKAY, resp);
		m_upaf = int'(af);
		m_upae = int'(ae);
	endtask

	// ==========================================================
	// data ports
	// ==========================================================
	task automatic ram_write(input logic [ADDR_BITS-1:0] addr, input word_t data,
		input logic [1:0] be);
		int row;
		row     = int'(addr[ADDR_BITS-1:4]);
		wen_a   = 1'b1;
		addr_a  = addr;
		wdata_a = data;
		be_a    = be;
		shadow[row] = ref_merge(shadow[row], cur_wmode, addr[3:0], data, be);
		@(negedge CLK_A);
		wen_a = 1'b0;
	endtask

	task automatic ram_read(input logic [ADDR_BITS-1:0] addr);
		int row;
		row       = int'(addr[ADDR_BITS-1:4]);
		ren_b     = 1'b1;
		addr_b    = addr;
		expect_rd = 1'b1;
		rd_exp_q.push_back(ref_extract(shadow[row], cur_rmode, addr[3:0]));
		@(negedge CLK_A);
		ren_b     = 1'b0;
		expect_rd = 1'b0;
	endtask

	task automatic fifo_push(input word_t data);
		wen_a   = 1'b1;
		wdata_a = data;
		if (fifo_q.size() == DEPTH) begin
			m_ovr = 1'b1;
		end else begin
			fifo_q.push_back(data);
		end
		fl_exp_q.push_back(ref_flags(fifo_q.size(), m_upaf, m_upae, m_ovr, m_und));
		expect_fl = 1'b1;
		@(negedge CLK_A);
		wen_a     = 1'b0;
		expect_fl = 1'b0;
	endtask

	task automatic fifo_pop();
		ren_b = 1'b1;
		if (fifo_q.size() == 0) begin
			m_und = 1'b1;
		end else begin
			rd_exp_q.push_back(fifo_q.pop_front());
			expect_rd = 1'b1;
		end
		fl_exp_q.push_back(ref_flags(fifo_q.size(), m_upaf, m_upae, m_ovr, m_und));
		expect_fl = 1'b1;
		@(negedge CLK_A);
		ren_b     = 1'b0;
		expect_rd = 1'b0;
		expect_fl = 1'b0;
	endtask

	// ==========================================================
	// compare process
	// ==========================================================
	always @(posedge CLK_A) begin
		rd_due <= expect_rd;
		fl_due <= expect_fl;
	end

	always @(negedge CLK_A) begin : compare_outputs
		word_t      exp_word;
		logic [5:0] exp_flags;
		logic [5:0] got_flags;
		got_flags = {underrun, overrun, almost_full, full, almost_empty, empty};
		if (rd_due) begin
			if (rd_exp_q.size() == 0) begin
				err_count++;
				$display("%s: read data arrived with no expected value", cur_test);
			end else begin
				exp_word = rd_exp_q.pop_front();
				if (rdata_b !== exp_word) report_mismatch("rdata_b", exp_word, rdata_b);
			end
		end
		if (fl_due) begin
			if (fl_exp_q.size() == 0) begin
				err_count++;
				$display("%s: flag check due with no expected value", cur_test);
			end else begin
				exp_flags = fl_exp_q.pop_front();
				if (got_flags !== exp_flags) report_mismatch("flags", exp_flags, got_flags);
			end
		end
	end

	initial begin : watchdog
		int cycle_count;
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge CLK_A);
			cycle_count++;
		end
		$display("timeout: run stopped after %0d cycles without finishing", cycle_count);
		$display("Errors found");
		$finish;
	end

	// ==========================================================
	// stimulus
	// ==========================================================
	initial begin : stimulus
		int                   i;
		int                   mi;
		int                   row;
		logic [1:0]           resp;
		axi_data_t            val;
		axi_data_t            rd;
		logic [ADDR_BITS-1:0] addrs [32];
		width_mode_t          narrow_modes [4];

		void'($urandom(RAND_SEED));
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = 4'h0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		wen_a     = 1'b0;
		addr_a    = '0;
		wdata_a   = '0;
		be_a      = 2'b00;
		ren_b     = 1'b0;
		addr_b    = '0;
		expect_rd = 1'b0;
		expect_fl = 1'b0;
		m_ovr     = 1'b0;
		m_und     = 1'b0;
		m_upaf    = 0;
		m_upae    = 0;
		cur_wmode = MODE_OFF;
		cur_rmode = MODE_OFF;
		err_count    = 0;
		tests_run    = 0;
		tests_failed = 0;
		narrow_modes = '{MODE_9, MODE_4, MODE_2, MODE_1};
		wait (arst_n === 1'b1);
		@(negedge CLK_A);

		begin_test("registers");
		val = $urandom;
		axi_write(REG_CTRL, val, resp);
		if (resp !== RESP_OKAY) report_mismatch("CTRL write response", RESP_OKAY, resp);
		axi_read(REG_CTRL, rd, resp);
		if (rd !== (val & 32'h0000_013f)) report_mismatch("CTRL readback", val & 32'h13f, rd);
		val = $urandom;
		axi_write(REG_THRESH, val, resp);
		m_upaf = int'(val[10:0]);
		m_upae = int'(val[26:16]);
		axi_read(REG_THRESH, rd, resp);
		if (rd !== (val & 32'h07ff_07ff)) begin
			report_mismatch("THRESH readback", val & 32'h07ff_07ff, rd);
		end
		axi_write(REG_CTRL, 32'h0000_0200, resp);
		axi_read(REG_CTRL, rd, resp);
		if (rd !== 32'h0) report_mismatch("flush bit readback", 32'h0, rd);
		axi_write(REG_STATUS, 32'hffff_ffff, resp);
		if (resp !== RESP_SLVERR) report_mismatch("STATUS write response", RESP_SLVERR, resp);
		axi_read(REG_STATUS, rd, resp);
		val = {26'd0, ref_flags(0, m_upaf, m_upae, 1'b0, 1'b0)};
		if (rd !== val) report_mismatch("STATUS readback", val, rd);
		axi_read(4'hc, rd, resp);
		if (resp !== RESP_SLVERR) report_mismatch("unknown offset response", RESP_SLVERR, resp);
		if (rd !== 32'h0) report_mismatch("unknown offset data", 32'h0, rd);
		end_test();

		begin_test("ram18");
		set_ctrl(MODE_18, MODE_18, 1'b0, 1'b0);
		for (i = 0; i < DEPTH; i++) begin
			ram_write(ADDR_BITS'(i * 16), fill_word(i), 2'b11);
		end
		// each write is read back in the very next cycle.
		for (i = 0; i < 64; i++) begin
			row = $urandom % DEPTH;
			ram_write(ADDR_BITS'(row * 16), word_t'($urandom), 2'($urandom));
			ram_read(ADDR_BITS'(row * 16));
		end
		end_test();

		begin_test("narrow");
		for (mi = 0; mi < 4; mi++) begin
			set_ctrl(narrow_modes[mi], narrow_modes[mi], 1'b0, 1'b0);
			for (i = 0; i < 32; i++) begin
				addrs[i] = ADDR_BITS'($urandom);
				ram_write(addrs[i], word_t'($urandom), 2'b11);
			end
			for (i = 0; i < 32; i++) begin
				ram_read(addrs[i]);
			end
			set_ctrl(narrow_modes[mi], MODE_18, 1'b0, 1'b0);
			for (i = 0; i < 32; i++) begin
				ram_read({addrs[i][ADDR_BITS-1:4], 4'h0});
			end
		end
		end_test();

		begin_test("fifo_order");
		set_thresh(11'd0, 11'd0);
		set_ctrl(MODE_18, MODE_18, 1'b1, 1'b1);
		for (i = 0; i < 40; i++) fifo_push(word_t'($urandom));
		for (i = 0; i < 40; i++) fifo_pop();
		for (i = 0; i < DEPTH; i++) fifo_push(word_t'($urandom));
		if (full !== 1'b1) report_mismatch("full after 1024 pushes", 1, full);
		end_test();

		begin_test("over_under");
		fifo_push(word_t'($urandom));
		for (i = 0; i < DEPTH; i++) fifo_pop();
		fifo_pop();
		for (i = 0; i < 3; i++) fifo_push(word_t'($urandom));
		set_ctrl(MODE_18, MODE_18, 1'b1, 1'b1);
		axi_read(REG_STATUS, rd, resp);
		val = {26'd0, ref_flags(0, m_upaf, m_upae, 1'b0, 1'b0)};
		if (rd !== val) report_mismatch("STATUS after flush", val, rd);
		fifo_push(word_t'($urandom));
		fifo_pop();
		end_test();

		begin_test("thresholds");
		set_thresh(11'd8, 11'd4);
		set_ctrl(MODE_18, MODE_18, 1'b1, 1'b1);
		for (i = 0; i < DEPTH; i++) fifo_push(word_t'($urandom));
		for (i = 0; i < DEPTH; i++) fifo_pop();
		end_test();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			err_count);
		if (err_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- bram_fifo.f
hdl/bram_fifo_pkg.sv
hdl/bram_cfg_if.sv
hdl/sram_dp.sv
hdl/fifo_ctl.sv
hdl/lane_align.sv
hdl/bram_regs.sv
hdl/bram_fifo.sv
test/tb_clock.sv
test/bram_fifo_tb.sv

//--- Makefile
SIM    := verilator
FLAGS  := --binary --timing --assert -Wno-fatal
TOP    := bram_fifo_tb
FLIST  := bram_fifo.f
OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)
SRCS   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

# pass only when the testbench prints the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJDIR)
